//--- logic/hist_cfg_pkg.sv
package hist_cfg_pkg;

    // time-bin index width, 16 bins per pixel
    localparam int BIN_W = 4;
    // pixel index width, 4 pixels
    localparam int PIXEL_W = 2;
    // bin address inside one bank, pixel-major
    localparam int BIN_IDX_W = PIXEL_W + BIN_W;
    localparam int PIXEL_NUM = 1 << PIXEL_W;
    localparam int BIN_TOTAL = 1 << BIN_IDX_W;
    // widest count word, modules narrow to COUNT_W
    localparam int COUNT_MAX_W = 8;
    // completed frames, shown in STATUS[31:16]
    localparam int FRAME_W = 16;

    typedef logic [BIN_W-1:0] bin_t;
    typedef logic [PIXEL_W-1:0] pixel_t;
    typedef logic [BIN_IDX_W-1:0] bin_idx_t;
    typedef logic [COUNT_MAX_W-1:0] count_t;
    typedef logic [FRAME_W-1:0] frame_cnt_t;

    // sequencer states
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        ACCUM = 2'd1,
        SWAP  = 2'd2
    } seq_state_t;

    // position of the hit being accepted
    typedef struct packed {
        pixel_t pixel;
        // final hit of the frame
        logic   last;
    } cnt_pos_t;

endpackage

//--- logic/hist_bus_pkg.sv
package hist_bus_pkg;

    typedef logic [11:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // master side of the bus
    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    // slave side of the bus
    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    // register map
    // bit 0 enable, read/write
    localparam apb_addr_t CTRL_OFS = 12'h000;
    // read only, hist_num and frame count
    localparam apb_addr_t STATUS_OFS = 12'h004;
    // readout window, one word per bin, pixel-major
    localparam apb_addr_t WIN_BASE = 12'h100;

endpackage

//--- logic/acq_counters.sv
`timescale 1ns/1ps

module acq_counters #(
    parameter int HITS_PER_PIXEL = 4,
    parameter int ACQ_NUM = 8
) (
    input  logic                   clk,
    input  logic                   combin_res,
    input  logic                   acc_en,
    input  logic                   hit_valid,
    output hist_cfg_pkg::cnt_pos_t pos
);
    import hist_cfg_pkg::*;

    // at least one bit even for a limit of 1
    localparam int HIT_W = (HITS_PER_PIXEL > 1) ? $clog2(HITS_PER_PIXEL) : 1;
    localparam int ACQ_W = (ACQ_NUM > 1) ? $clog2(ACQ_NUM) : 1;

    logic [HIT_W-1:0] hit_cnt;
    pixel_t           pixel_cnt;
    logic [ACQ_W-1:0] acq_cnt;

    logic step;
    logic hit_wrap;
    logic pixel_wrap;
    logic acq_wrap;

    // one step per accepted hit
    assign step = acc_en && hit_valid;

    // each counter sits at its final value
    assign hit_wrap   = (hit_cnt == HIT_W'(HITS_PER_PIXEL - 1));
    assign pixel_wrap = (pixel_cnt == pixel_t'(PIXEL_NUM - 1));
    assign acq_wrap   = (acq_cnt == ACQ_W'(ACQ_NUM - 1));

    // position of the hit accepted this cycle
    assign pos.pixel = pixel_cnt;
    assign pos.last  = hit_wrap && pixel_wrap && acq_wrap;

    // hits per pixel, then pixels, then acquisitions
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            hit_cnt   <= '0;
            pixel_cnt <= '0;
            acq_cnt   <= '0;
        end else if (step) begin
            if (!hit_wrap) begin
                hit_cnt <= hit_cnt + 1'b1;
            end else begin
                hit_cnt <= '0;
                if (!pixel_wrap) begin
                    pixel_cnt <= pixel_cnt + 1'b1;
                end else begin
                    pixel_cnt <= '0;
                    // frame done, everything back to zero
                    if (!acq_wrap) begin
                        acq_cnt <= acq_cnt + 1'b1;
                    end else begin
                        acq_cnt <= '0;
                    end
                end
            end
        end
    end

    // counters stay inside their ranges
    a_cnt_range: assert property (@(posedge clk) disable iff (!combin_res)
        (hit_cnt <= HIT_W'(HITS_PER_PIXEL - 1)) && (acq_cnt <= ACQ_W'(ACQ_NUM - 1)));

    // frame position frozen outside ACCUM
    a_cnt_hold: assert property (@(posedge clk) disable iff (!combin_res)
        !acc_en |=> $stable({hit_cnt, pixel_cnt, acq_cnt}));

endmodule

//--- logic/hist_seq_fsm.sv
`timescale 1ns/1ps

module hist_seq_fsm (
    input  logic                     clk,
    input  logic                     combin_res,
    input  logic                     enable,
    input  logic                     hit_valid,
    input  hist_cfg_pkg::cnt_pos_t   pos,
    output logic                     acc_en,
    output logic                     swap,
    output logic                     hist_num,
    output hist_cfg_pkg::frame_cnt_t frame_count
);
    import hist_cfg_pkg::*;

    seq_state_t state_q;
    seq_state_t state_d;

    logic frame_done;

    // last hit of the frame accepted this cycle
    assign frame_done = acc_en && hit_valid && pos.last;

    // hits only flow in ACCUM
    assign acc_en = (state_q == ACCUM);
    // one stall cycle per frame
    assign swap = (state_q == SWAP);

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                if (enable) begin
                    state_d = ACCUM;
                end
            end
            ACCUM: begin
                // frame end wins over a dropped enable
                if (frame_done) begin
                    state_d = SWAP;
                end else if (!enable) begin
                    state_d = IDLE;
                end
            end
            SWAP: begin
                state_d = enable ? ACCUM : IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state_q     <= IDLE;
            hist_num    <= 1'b0;
            frame_count <= '0;
        end else begin
            state_q <= state_d;
            // bank flip and frame tally at the end of SWAP
            if (swap) begin
                hist_num    <= ~hist_num;
                frame_count <= frame_count + 1'b1;
            end
        end
    end

    // SWAP holds for one cycle only
    a_swap_single: assert property (@(posedge clk) disable iff (!combin_res)
        swap |=> !swap);

endmodule

//--- logic/hist_bank.sv
`timescale 1ns/1ps

module hist_bank #(
    parameter int COUNT_W = 8
) (
    input  logic                   clk,
    input  logic                   combin_res,
    input  logic                   acc_en,
    input  logic                   hit_valid,
    input  hist_cfg_pkg::bin_t     hit_bin,
    input  hist_cfg_pkg::cnt_pos_t pos,
    input  logic                   swap,
    input  logic                   hist_num,
    input  hist_cfg_pkg::bin_idx_t rd_index,
    output hist_cfg_pkg::count_t   rd_count
);
    import hist_cfg_pkg::*;

    // saturation value
    localparam logic [COUNT_W-1:0] CNT_MAX = '1;

    // count words, two banks
    logic [COUNT_W-1:0] cnt_mem [2][BIN_TOTAL];
    // one valid flag per bin, per bank
    logic [1:0][BIN_TOTAL-1:0] vld;

    logic               wr_en;
    bin_idx_t           wr_addr;
    logic               wr_vld;
    logic [COUNT_W-1:0] wr_old;
    logic               rd_bank;
    logic               rd_vld;
    logic [COUNT_W-1:0] rd_word;

    // accepted hit goes to the write bank
    assign wr_en = acc_en && hit_valid;
    // pixel * 16 + bin
    assign wr_addr = {pos.pixel, hit_bin};
    assign wr_vld  = vld[hist_num][wr_addr];
    assign wr_old  = cnt_mem[hist_num][wr_addr];

    // payload update, no reset, valid flags decide meaning
    always_ff @(posedge clk) begin
        if (wr_en) begin
            if (!wr_vld) begin
                // first hit of this frame in the bin
                cnt_mem[hist_num][wr_addr] <= COUNT_W'(1);
            end else if (wr_old != CNT_MAX) begin
                cnt_mem[hist_num][wr_addr] <= wr_old + 1'b1;
            end
        end
    end

    // valid flags act as the bank clear
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            vld <= '0;
        end else if (swap) begin
            // bank about to become the write bank
            vld[~hist_num] <= '0;
        end else if (wr_en) begin
            vld[hist_num][wr_addr] <= 1'b1;
        end
    end

    // readout from the frozen bank
    assign rd_bank = ~hist_num;
    assign rd_vld  = vld[rd_bank][rd_index];
    assign rd_word = cnt_mem[rd_bank][rd_index];

    // stale bins read as zero
    assign rd_count = rd_vld ? count_t'(rd_word) : '0;

    // the sequencer never writes during the swap cycle
    a_no_wr_swap: assert property (@(posedge clk) disable iff (!combin_res)
        swap |-> !wr_en);

endmodule

//--- logic/apb_hist_regs.sv
`timescale 1ns/1ps

module apb_hist_regs #(
    parameter int COUNT_W = 8
) (
    input  logic                     clk,
    input  logic                     combin_res,
    input  hist_bus_pkg::apb_req_t   apb_req,
    output hist_bus_pkg::apb_rsp_t   apb_rsp,
    output logic                     enable,
    input  logic                     hist_num,
    input  hist_cfg_pkg::frame_cnt_t frame_count,
    output hist_cfg_pkg::bin_idx_t   rd_index,
    input  hist_cfg_pkg::count_t     rd_count
);
    import hist_cfg_pkg::*;
    import hist_bus_pkg::*;

    // first byte past the window
    localparam apb_addr_t WIN_END = WIN_BASE + apb_addr_t'(4 * BIN_TOTAL);

    logic      setup;
    logic      access;
    logic      hit_ctrl;
    logic      hit_status;
    logic      hit_win;
    logic      dec_err;
    logic      slverr_q;
    apb_addr_t win_ofs;
    apb_data_t rdata;

    // APB phases
    assign setup  = apb_req.psel && !apb_req.penable;
    assign access = apb_req.psel && apb_req.penable;

    // address decode
    assign hit_ctrl   = (apb_req.paddr == CTRL_OFS);
    assign hit_status = (apb_req.paddr == STATUS_OFS);
    assign hit_win    = (apb_req.paddr >= WIN_BASE) && (apb_req.paddr < WIN_END) &&
                        (apb_req.paddr[1:0] == 2'b00);

    // word offset inside the window
    assign win_ofs  = apb_req.paddr - WIN_BASE;
    assign rd_index = win_ofs[BIN_IDX_W+1:2];

    // only CTRL takes writes, unmapped offsets always fail
    assign dec_err = !(hit_ctrl || ((hit_status || hit_win) && !apb_req.pwrite));

    // error decided in setup, shown in the access cycle
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            slverr_q <= 1'b0;
        end else if (setup) begin
            slverr_q <= dec_err;
        end else begin
            slverr_q <= 1'b0;
        end
    end

    // CTRL bit 0
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            enable <= 1'b0;
        end else if (access && apb_req.pwrite && hit_ctrl) begin
            enable <= apb_req.pwdata[0];
        end
    end

    // read mux, all sources are flops
    always_comb begin
        rdata = '0;
        if (access && !apb_req.pwrite) begin
            if (hit_ctrl) begin
                rdata[0] = enable;
            end else if (hit_status) begin
                rdata[0]     = hist_num;
                rdata[31:16] = frame_count;
            end else if (hit_win) begin
                // upper bits zero
                rdata = apb_data_t'(rd_count[COUNT_W-1:0]);
            end
        end
    end

    // no wait states
    assign apb_rsp.prdata  = rdata;
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = slverr_q;

    // master keeps psel through the access phase
    a_penable_psel: assert property (@(posedge clk) disable iff (!combin_res)
        apb_req.penable |-> apb_req.psel && $past(apb_req.psel));

endmodule

//--- logic/hist_top.sv
`timescale 1ns/1ps

module hist_top #(
    parameter int HITS_PER_PIXEL = 4,
    parameter int ACQ_NUM = 8,
    parameter int COUNT_W = 8
) (
    input  logic                    clk,
    input  logic                    combin_res,
    input  logic                    hit_valid,
    input  hist_cfg_pkg::bin_t      hit_bin,
    output logic                    hit_ready,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  hist_bus_pkg::apb_addr_t paddr,
    input  hist_bus_pkg::apb_data_t pwdata,
    output hist_bus_pkg::apb_data_t prdata,
    output logic                    pready,
    output logic                    pslverr,
    output logic                    hist_num
);
    import hist_cfg_pkg::*;
    import hist_bus_pkg::*;

    // count words live in count_t
    if (COUNT_W < 1 || COUNT_W > COUNT_MAX_W) begin : g_count_w_check
        $error("COUNT_W out of range");
    end

    apb_req_t   apb_req;
    apb_rsp_t   apb_rsp;
    cnt_pos_t   pos;
    logic       acc_en;
    logic       swap;
    logic       enable;
    frame_cnt_t frame_count;
    bin_idx_t   rd_index;
    count_t     rd_count;

    // bus ports into the request struct
    assign apb_req.psel    = psel;
    assign apb_req.penable = penable;
    assign apb_req.pwrite  = pwrite;
    assign apb_req.paddr   = paddr;
    assign apb_req.pwdata  = pwdata;

    assign prdata  = apb_rsp.prdata;
    assign pready  = apb_rsp.pready;
    assign pslverr = apb_rsp.pslverr;

    // stream accepted only in ACCUM
    assign hit_ready = acc_en;

    acq_counters #(
        .HITS_PER_PIXEL(HITS_PER_PIXEL),
        .ACQ_NUM       (ACQ_NUM)
    ) u_counters (
        .clk       (clk),
        .combin_res(combin_res),
        .acc_en    (acc_en),
        .hit_valid (hit_valid),
        .pos       (pos)
    );

    hist_seq_fsm u_seq (
        .clk        (clk),
        .combin_res (combin_res),
        .enable     (enable),
        .hit_valid  (hit_valid),
        .pos        (pos),
        .acc_en     (acc_en),
        .swap       (swap),
        .hist_num   (hist_num),
        .frame_count(frame_count)
    );

    hist_bank #(
        .COUNT_W(COUNT_W)
    ) u_bank (
        .clk       (clk),
        .combin_res(combin_res),
        .acc_en    (acc_en),
        .hit_valid (hit_valid),
        .hit_bin   (hit_bin),
        .pos       (pos),
        .swap      (swap),
        .hist_num  (hist_num),
        .rd_index  (rd_index),
        .rd_count  (rd_count)
    );

    apb_hist_regs #(
        .COUNT_W(COUNT_W)
    ) u_regs (
        .clk        (clk),
        .combin_res (combin_res),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .enable     (enable),
        .hist_num   (hist_num),
        .frame_count(frame_count),
        .rd_index   (rd_index),
        .rd_count   (rd_count)
    );

endmodule

//--- testbench/tb_hist_top.sv
`timescale 1ns/1ps

module tb_hist_top;
    import hist_cfg_pkg::*;
    import hist_bus_pkg::*;

    localparam int HPP = 4;
    localparam int ACQ = 8;
    localparam int CW = 4;
    localparam int FRAME_HITS = HPP * PIXEL_NUM * ACQ;
    // saturation value for a 4-bit count
    localparam int CAP = (1 << CW) - 1;
    // reset, 4 frames with one stall each, about 360 APB transfers of 3 cycles
    localparam int RUN_CYCLES = 8 + 4 * (FRAME_HITS + 1) + 3 * 360 + 32;

    logic      clk = 1'b0;
    logic      combin_res;
    logic      hit_valid;
    bin_t      hit_bin;
    logic      hit_ready;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
    logic      hist_num;

    // reference counts of the current frame, unsaturated
    int          model [BIN_TOTAL];
    // index of the next hit inside the frame
    int          hit_pos;
    logic        last_q1;
    logic        last_q2;
    // mirror of CTRL bit 0
    logic        ctrl_en;
    logic [31:0] rng;
    int          frames;
    int          errors;
    int          checks;
    int          tests;
    int          bad_tests;
    int          test_err0;

    hist_top #(
        .HITS_PER_PIXEL(HPP),
        .ACQ_NUM       (ACQ),
        .COUNT_W       (CW)
    ) DUT (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // frame count on top, write bank in bit 0
    function automatic apb_data_t status_word(input int f);
        return {frame_cnt_t'(f), 15'd0, f[0]};
    endfunction

    // frame position and the two cycles after a frame's last hit
    always @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            hit_pos <= 0;
            last_q1 <= 1'b0;
            last_q2 <= 1'b0;
        end else begin
            last_q1 <= hit_valid && hit_ready && (hit_pos == FRAME_HITS - 1);
            last_q2 <= last_q1;
            if (hit_valid && hit_ready) begin
                hit_pos <= (hit_pos == FRAME_HITS - 1) ? 0 : hit_pos + 1;
            end
        end
    end

    // swap cycle stalls the stream
    a_stall_low: assert property (@(posedge clk) disable iff (!combin_res)
        last_q1 |-> !hit_ready)
        else begin
            errors++;
            $display("[ERROR] %0t ns hit_ready expected 0 got 1 in the swap cycle", $time);
        end

    // and only for one cycle
    a_stall_one: assert property (@(posedge clk) disable iff (!combin_res)
        (last_q2 && ctrl_en) |-> hit_ready)
        else begin
            errors++;
            $display("[ERROR] %0t ns hit_ready expected 1 got 0 after the swap", $time);
        end

    task automatic expect_eq(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        checks++;
        assert (act === exp)
            else begin
                errors++;
                $display("[ERROR] %0t ns %s expected 0x%0h got 0x%0h", $time, name, exp, act);
            end
    endtask

    // setup then access, sampled mid access cycle
    task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        // no wait states on this slave
        expect_eq("pready", 32'd1, 32'(pready));
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic read_check(input string name, input apb_addr_t addr, input apb_data_t exp);
        apb_data_t rd;
        logic      err;
        apb_xfer(1'b0, addr, '0, rd, err);
        expect_eq(name, exp, rd);
        expect_eq("pslverr", 32'd0, 32'(err));
    endtask

    task automatic write_ctrl(input logic en);
        apb_data_t rd;
        logic      err;
        apb_xfer(1'b1, CTRL_OFS, 32'(en), rd, err);
        expect_eq("pslverr", 32'd0, 32'(err));
        ctrl_en = en;
    endtask

    // hold the hit until hit_ready, count it in the model
    task automatic send_hit(input bin_t b);
        int idx;
        hit_valid <= 1'b1;
        hit_bin   <= b;
        @(negedge clk);
        while (!hit_ready) begin
            @(negedge clk);
        end
        // pixel-major bin address
        idx = ((hit_pos / HPP) % PIXEL_NUM) * (1 << BIN_W) + int'(b);
        model[idx]++;
        @(posedge clk);
    endtask

    task automatic run_hits(input int n, input logic fixed, input bin_t fbin);
        for (int i = 0; i < n; i++) begin
            rng = xorshift32(rng);
            send_hit(fixed ? fbin : bin_t'(rng[BIN_W-1:0]));
        end
        hit_valid <= 1'b0;
    endtask

    task automatic clear_model();
        foreach (model[i]) begin
            model[i] = 0;
        end
    endtask

    task automatic check_window();
        for (int i = 0; i < BIN_TOTAL; i++) begin
            read_check($sformatf("prdata win[%0d]", i), WIN_BASE + apb_addr_t'(4 * i),
                       (model[i] > CAP) ? CAP : model[i]);
        end
    endtask

    // bank flip lands one cycle after the last hit
    task automatic check_frame();
        @(posedge clk);
        @(negedge clk);
        expect_eq("hist_num", 32'(frames % 2), 32'(hist_num));
        @(posedge clk);
        read_check("prdata STATUS", STATUS_OFS, status_word(frames));
        check_window();
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors != test_err0) begin
            bad_tests++;
        end
        $display("[T%0d] %s: %0d errors", tests, name, errors - test_err0);
        test_err0 = errors;
    endtask

    initial begin
        #(RUN_CYCLES * 40);
        $display("watchdog expired after %0d cycles, the DUT stopped responding",
                 RUN_CYCLES * 2);
        $display("test failed");
        $finish;
    end

    initial begin
        apb_data_t rd;
        logic      err;
        combin_res <= 1'b0;
        hit_valid  <= 1'b0;
        hit_bin    <= '0;
        psel       <= 1'b0;
        penable    <= 1'b0;
        pwrite     <= 1'b0;
        paddr      <= '0;
        pwdata     <= '0;
        rng     = 32'h22ce_ab70;
        ctrl_en = 1'b0;
        clear_model();
        repeat (8) @(posedge clk);
        combin_res <= 1'b1;
        @(posedge clk);

        // everything idle and empty
        @(negedge clk);
        expect_eq("hit_ready", 32'd0, 32'(hit_ready));
        expect_eq("hist_num", 32'd0, 32'(hist_num));
        @(posedge clk);
        read_check("prdata STATUS", STATUS_OFS, 32'd0);
        read_check("prdata CTRL", CTRL_OFS, 32'd0);
        check_window();
        finish_test("reset values");

        write_ctrl(1'b1);
        run_hits(FRAME_HITS, 1'b0, '0);
        frames++;
        check_frame();
        finish_test("first random frame");

        // second bank, first frame stays frozen in the other one
        clear_model();
        run_hits(FRAME_HITS, 1'b0, '0);
        frames++;
        check_frame();
        finish_test("second random frame");

        // 32 hits per pixel into bin 9
        // bank of frame one reused, its other bins must read 0
        clear_model();
        run_hits(FRAME_HITS, 1'b1, 4'd9);
        frames++;
        check_frame();
        finish_test("saturation");

        clear_model();
        run_hits(FRAME_HITS / 2 + 3, 1'b0, '0);
        write_ctrl(1'b0);
        // FSM leaves ACCUM one cycle after enable drops
        @(posedge clk);
        hit_valid <= 1'b1;
        hit_bin   <= 4'd3;
        repeat (6) begin
            @(negedge clk);
            expect_eq("hit_ready", 32'd0, 32'(hit_ready));
        end
        @(posedge clk);
        hit_valid <= 1'b0;
        write_ctrl(1'b1);
        run_hits(FRAME_HITS - FRAME_HITS / 2 - 3, 1'b0, '0);
        frames++;
        check_frame();
        finish_test("enable pause and resume");

        apb_xfer(1'b0, 12'h008, '0, rd, err);
        expect_eq("pslverr", 32'd1, 32'(err));
        apb_xfer(1'b1, STATUS_OFS, 32'hffff_ffff, rd, err);
        expect_eq("pslverr", 32'd1, 32'(err));
        apb_xfer(1'b1, 12'h0f0, 32'h0, rd, err);
        expect_eq("pslverr", 32'd1, 32'(err));
        read_check("prdata CTRL", CTRL_OFS, 32'd1);
        read_check("prdata STATUS", STATUS_OFS, status_word(frames));
        finish_test("bus errors");

        $display("summary: %0d tests, %0d with errors, %0d checks, %0d errors",
                 tests, bad_tests, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- tb.f
logic/hist_cfg_pkg.sv
logic/hist_bus_pkg.sv
logic/acq_counters.sv
logic/hist_seq_fsm.sv
logic/hist_bank.sv
logic/apb_hist_regs.sv
logic/hist_top.sv
testbench/tb_hist_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the histogram testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_hist_top -f tb.f \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/Vtb_hist_top > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log
# the log decides the result
! grep -q "test failed" sim.log && grep -q "test passed" sim.log \
    && echo "simulation ok" \
    || { echo "simulation reported failure"; exit 1; }
